/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// alu operations, shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// word access only
	localparam logic [2:0] F3_LW = 3'b010;
	localparam logic [2:0] F3_SW = 3'b010;

	// funct7, the alternate form selects sub and sra
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

endpackage

/* source/core_types_pkg.sv */
package core_types_pkg;

	localparam int XLEN = 32;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
	} fetch_pl_t;

	// for branches op_b holds the offset and rs2_val is the compare operand
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
		logic [XLEN-1:0] rs2_val;
		logic [4:0]      rd;
		logic            wen;
		alu_op_e         alu_op;
		logic [2:0]      br_funct3;
		logic            is_branch;
		logic            is_jump;
		logic            is_load;
		logic            is_store;
		logic            halt;
	} decode_pl_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] store_data;
		logic [4:0]      rd;
		logic            wen;
		logic            is_load;
		logic            is_store;
		logic            halt;
		logic            redirect;
		logic [XLEN-1:0] redirect_pc;
	} exec_pl_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [4:0]      rd;
		logic            wen;
		logic [XLEN-1:0] wdata;
		logic            halt;
		logic            redirect;
		logic [XLEN-1:0] redirect_pc;
	} wb_pl_t;

endpackage

/* source/stage_if.sv */
interface stage_if #(
	parameter type payload_t = logic
);

	logic     valid;
	logic     ready;
	payload_t payload;

	// payload is held by the source until valid and ready meet
	modport src (output valid, output payload, input ready);
	modport dst (input valid, input payload, output ready);

endinterface

/* source/ifu.sv */
module ifu import core_types_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            arst_n_i,

	output logic            inst_req_valid_o,
	input  logic            inst_req_ready_i,
	output logic [XLEN-1:0] inst_addr_o,
	input  logic            inst_rsp_valid_i,
	output logic            inst_rsp_ready_o,
	input  logic [31:0]     inst_data_i,

	input  logic            retire_i,
	input  logic            redirect_i,
	input  logic [XLEN-1:0] redirect_pc_i,
	input  logic            halted_i,

	stage_if.src            fetch_o
);

	typedef enum logic [1:0] {
		S_REQ,
		S_WAIT_RSP,
		S_HAND,
		S_WAIT_RET
	} state_e;

	state_e          state_q;
	logic            boot_q;
	logic [XLEN-1:0] pc_q;
	logic [31:0]     inst_q;

	assign inst_req_valid_o = (state_q == S_REQ);
	assign inst_addr_o      = pc_q;
	assign inst_rsp_ready_o = (state_q == S_WAIT_RSP);
	assign fetch_o.valid    = (state_q == S_HAND);
	assign fetch_o.payload  = '{pc: pc_q, inst: inst_q};

	// boot_q acts as the first retire, so fetch starts one cycle after reset
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= S_WAIT_RET;
			boot_q  <= 1'b1;
			pc_q    <= RESET_PC;
		end else begin
			boot_q <= 1'b0;
			case (state_q)
				S_REQ: begin
					if (inst_req_ready_i)
						state_q <= S_WAIT_RSP;
				end
				S_WAIT_RSP: begin
					if (inst_rsp_valid_i)
						state_q <= S_HAND;
				end
				S_HAND: begin
					if (fetch_o.ready)
						state_q <= S_WAIT_RET;
				end
				S_WAIT_RET: begin
					if (retire_i)
						pc_q <= redirect_i ? redirect_pc_i : pc_q + XLEN'(4);
					// a halting instruction parks the fsm here for good
					if ((retire_i || boot_q) && !halted_i)
						state_q <= S_REQ;
				end
				default: state_q <= S_WAIT_RET;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (inst_rsp_valid_i && inst_rsp_ready_o)
			inst_q <= inst_data_i;
	end

endmodule

/* source/regfile.sv */
module regfile import core_types_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic [4:0]      raddr1_i,
	input  logic [4:0]      raddr2_i,
	output logic [XLEN-1:0] rdata1_o,
	output logic [XLEN-1:0] rdata2_o,
	input  logic            wen_i,
	input  logic [4:0]      waddr_i,
	input  logic [XLEN-1:0] wdata_i
);

	// x0 has no storage
	logic [XLEN-1:0] regs_q [1:31];

	assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs_q[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs_q[raddr2_i];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++)
				regs_q[i] <= '0;
		end else if (wen_i && (waddr_i != 5'd0)) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

endmodule

/* source/idu.sv */
module idu import rv_isa_pkg::*; import core_types_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	stage_if.dst            fetch_i,
	output logic [4:0]      rs1_addr_o,
	output logic [4:0]      rs2_addr_o,
	input  logic [XLEN-1:0] rs1_data_i,
	input  logic [XLEN-1:0] rs2_data_i,
	stage_if.src            decode_o,
	output logic            illegal_o
);

	logic [31:0]     inst;
	logic [6:0]      opcode;
	logic [2:0]      f3;
	logic [6:0]      f7;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	decode_pl_t      dec;
	decode_pl_t      dec_q;
	logic            illegal;
	logic            valid_q;
	logic            illegal_q;
	logic            take;

	assign inst   = fetch_i.payload.inst;
	assign opcode = inst[6:0];
	assign f3     = inst[14:12];
	assign f7     = inst[31:25];

	assign rs1_addr_o = inst[19:15];
	assign rs2_addr_o = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign take             = fetch_i.valid && !valid_q;
	assign fetch_i.ready    = !valid_q;
	assign decode_o.valid   = valid_q;
	assign decode_o.payload = dec_q;
	assign illegal_o        = illegal_q;

	// alt selects sub or sra
	function automatic alu_op_e alu_from_f3(input logic [2:0] fn, input logic alt);
		case (fn)
			F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return alt ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		dec           = '0;
		illegal       = 1'b0;
		dec.pc        = fetch_i.payload.pc;
		dec.op_a      = rs1_data_i;
		dec.op_b      = rs2_data_i;
		dec.rs2_val   = rs2_data_i;
		dec.rd        = inst[11:7];
		dec.alu_op    = ALU_ADD;
		dec.br_funct3 = f3;
		case (opcode)
			OPC_LUI: begin
				dec.op_b   = imm_u;
				dec.alu_op = ALU_PASS_B;
				dec.wen    = 1'b1;
			end
			OPC_AUIPC: begin
				dec.op_a = fetch_i.payload.pc;
				dec.op_b = imm_u;
				dec.wen  = 1'b1;
			end
			OPC_JAL: begin
				dec.op_a    = fetch_i.payload.pc;
				dec.op_b    = imm_j;
				dec.wen     = 1'b1;
				dec.is_jump = 1'b1;
			end
			OPC_JALR: begin
				dec.op_b    = imm_i;
				dec.wen     = 1'b1;
				dec.is_jump = 1'b1;
				illegal     = (f3 != 3'b000);
			end
			OPC_BRANCH: begin
				dec.op_b      = imm_b;
				dec.is_branch = 1'b1;
				illegal       = (f3 == 3'b010) || (f3 == 3'b011);
			end
			OPC_LOAD: begin
				dec.op_b    = imm_i;
				dec.wen     = 1'b1;
				dec.is_load = 1'b1;
				illegal     = (f3 != F3_LW);
			end
			OPC_STORE: begin
				dec.op_b     = imm_s;
				dec.is_store = 1'b1;
				illegal      = (f3 != F3_SW);
			end
			OPC_OPIMM: begin
				dec.op_b   = imm_i;
				dec.wen    = 1'b1;
				dec.alu_op = alu_from_f3(f3, (f3 == F3_SR) && inst[30]);
				// shift immediates carry a funct7 of their own
				if (f3 == F3_SLL)
					illegal = (f7 != F7_BASE);
				else if (f3 == F3_SR)
					illegal = (f7 != F7_BASE) && (f7 != F7_ALT);
			end
			OPC_OP: begin
				dec.wen    = 1'b1;
				dec.alu_op = alu_from_f3(f3, inst[30]);
				illegal    = (f7 != F7_BASE) &&
				             !((f7 == F7_ALT) && ((f3 == F3_ADD) || (f3 == F3_SR)));
			end
			OPC_SYSTEM: begin
				dec.halt = (inst == INST_EBREAK);
				illegal  = (inst != INST_EBREAK);
			end
			default: illegal = 1'b1;
		endcase
		// turn a bad encoding into a plain halt
		if (illegal) begin
			dec.wen       = 1'b0;
			dec.is_branch = 1'b0;
			dec.is_jump   = 1'b0;
			dec.is_load   = 1'b0;
			dec.is_store  = 1'b0;
			dec.halt      = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q   <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			if (take)
				valid_q <= 1'b1;
			else if (decode_o.ready)
				valid_q <= 1'b0;
			if (take && illegal)
				illegal_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			dec_q <= dec;
	end

endmodule

/* source/exu.sv */
module exu import rv_isa_pkg::*; import core_types_pkg::*; (
	input logic  clk,
	input logic  arst_n_i,
	stage_if.dst decode_i,
	stage_if.src exec_o
);

	decode_pl_t      d;
	exec_pl_t        res;
	exec_pl_t        res_q;
	logic [XLEN-1:0] alu_res;
	logic            taken;
	logic            valid_q;
	logic            take;

	assign d              = decode_i.payload;
	assign take           = decode_i.valid && !valid_q;
	assign decode_i.ready = !valid_q;
	assign exec_o.valid   = valid_q;
	assign exec_o.payload = res_q;

	always_comb begin
		case (d.alu_op)
			ALU_ADD:  alu_res = d.op_a + d.op_b;
			ALU_SUB:  alu_res = d.op_a - d.op_b;
			ALU_SLL:  alu_res = d.op_a << d.op_b[4:0];
			ALU_SLT:  alu_res = XLEN'($signed(d.op_a) < $signed(d.op_b));
			ALU_SLTU: alu_res = XLEN'(d.op_a < d.op_b);
			ALU_XOR:  alu_res = d.op_a ^ d.op_b;
			ALU_SRL:  alu_res = d.op_a >> d.op_b[4:0];
			ALU_SRA:  alu_res = $unsigned($signed(d.op_a) >>> d.op_b[4:0]);
			ALU_OR:   alu_res = d.op_a | d.op_b;
			ALU_AND:  alu_res = d.op_a & d.op_b;
			default:  alu_res = d.op_b;
		endcase
	end

	// rs1 sits in op_a, rs2 in rs2_val
	always_comb begin
		case (d.br_funct3)
			F3_BEQ:  taken = (d.op_a == d.rs2_val);
			F3_BNE:  taken = (d.op_a != d.rs2_val);
			F3_BLT:  taken = ($signed(d.op_a) < $signed(d.rs2_val));
			F3_BGE:  taken = ($signed(d.op_a) >= $signed(d.rs2_val));
			F3_BLTU: taken = (d.op_a < d.rs2_val);
			F3_BGEU: taken = (d.op_a >= d.rs2_val);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		res.pc          = d.pc;
		res.result      = d.is_jump ? d.pc + XLEN'(4) : alu_res;
		res.store_data  = d.rs2_val;
		res.rd          = d.rd;
		res.wen         = d.wen;
		res.is_load     = d.is_load;
		res.is_store    = d.is_store;
		res.halt        = d.halt;
		res.redirect    = d.is_jump || (d.is_branch && taken);
		// jal and jalr both compute their target in the adder
		res.redirect_pc = d.is_branch ? d.pc + d.op_b : {alu_res[XLEN-1:1], 1'b0};
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			valid_q <= 1'b0;
		else if (take)
			valid_q <= 1'b1;
		else if (exec_o.ready)
			valid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take)
			res_q <= res;
	end

endmodule

/* source/lsu.sv */
module lsu import core_types_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	stage_if.dst            exec_i,

	output logic            data_req_valid_o,
	input  logic            data_req_ready_i,
	output logic            data_we_o,
	output logic [XLEN-1:0] data_addr_o,
	output logic [XLEN-1:0] data_wdata_o,
	input  logic            data_rsp_valid_i,
	output logic            data_rsp_ready_o,
	input  logic [XLEN-1:0] data_rdata_i,

	stage_if.src            mem_o
);

	typedef enum logic [1:0] {
		L_IDLE,
		L_REQ,
		L_RSP,
		L_OUT
	} state_e;

	state_e          state_q;
	exec_pl_t        pl_q;
	logic [XLEN-1:0] wdata_q;
	logic            take;

	assign take             = exec_i.valid && (state_q == L_IDLE);
	assign exec_i.ready     = (state_q == L_IDLE);
	assign data_req_valid_o = (state_q == L_REQ);
	assign data_we_o        = pl_q.is_store;
	assign data_addr_o      = pl_q.result;
	assign data_wdata_o     = pl_q.store_data;
	assign data_rsp_ready_o = (state_q == L_RSP);
	assign mem_o.valid      = (state_q == L_OUT);

	// stores never write a register
	assign mem_o.payload = '{
		pc:          pl_q.pc,
		rd:          pl_q.rd,
		wen:         pl_q.wen && !pl_q.is_store,
		wdata:       wdata_q,
		halt:        pl_q.halt,
		redirect:    pl_q.redirect,
		redirect_pc: pl_q.redirect_pc
	};

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= L_IDLE;
		end else begin
			case (state_q)
				L_IDLE: begin
					if (take)
						state_q <= (exec_i.payload.is_load || exec_i.payload.is_store) ?
						           L_REQ : L_OUT;
				end
				L_REQ: begin
					if (data_req_ready_i)
						state_q <= L_RSP;
				end
				L_RSP: begin
					if (data_rsp_valid_i)
						state_q <= L_OUT;
				end
				L_OUT: begin
					if (mem_o.ready)
						state_q <= L_IDLE;
				end
				default: state_q <= L_IDLE;
			endcase
		end
	end

	// load data overwrites the address held in the result slot
	always_ff @(posedge clk) begin
		if (take) begin
			pl_q    <= exec_i.payload;
			wdata_q <= exec_i.payload.result;
		end else if (data_rsp_valid_i && data_rsp_ready_o && pl_q.is_load) begin
			wdata_q <= data_rdata_i;
		end
	end

endmodule

/* source/wbu.sv */
module wbu import core_types_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	stage_if.dst            mem_i,
	output logic            reg_wen_o,
	output logic [4:0]      reg_waddr_o,
	output logic [XLEN-1:0] reg_wdata_o,
	output logic            retire_o,
	output logic [XLEN-1:0] retire_pc_o,
	output logic            redirect_o,
	output logic [XLEN-1:0] redirect_pc_o,
	output logic            halted_o
);

	logic halt_q;

	// never stalls, everything happens in the transfer cycle
	assign mem_i.ready   = 1'b1;
	assign reg_wen_o     = mem_i.valid && mem_i.payload.wen;
	assign reg_waddr_o   = mem_i.payload.rd;
	assign reg_wdata_o   = mem_i.payload.wdata;
	assign retire_o      = mem_i.valid;
	assign retire_pc_o   = mem_i.payload.pc;
	assign redirect_o    = mem_i.valid && mem_i.payload.redirect;
	assign redirect_pc_o = mem_i.payload.redirect_pc;

	// also high in the retire cycle, so ifu does not refetch
	assign halted_o = halt_q || (mem_i.valid && mem_i.payload.halt);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			halt_q <= 1'b0;
		else if (mem_i.valid && mem_i.payload.halt)
			halt_q <= 1'b1;
	end

endmodule

/* source/cpu_core.sv */
module cpu_core import core_types_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            arst_n_i,

	// instruction fetch bus
	output logic            inst_req_valid_o,
	input  logic            inst_req_ready_i,
	output logic [XLEN-1:0] inst_addr_o,
	input  logic            inst_rsp_valid_i,
	output logic            inst_rsp_ready_o,
	input  logic [31:0]     inst_data_i,

	// load/store bus
	output logic            data_req_valid_o,
	input  logic            data_req_ready_i,
	output logic            data_we_o,
	output logic [XLEN-1:0] data_addr_o,
	output logic [XLEN-1:0] data_wdata_o,
	input  logic            data_rsp_valid_i,
	output logic            data_rsp_ready_o,
	input  logic [XLEN-1:0] data_rdata_i,

	output logic            retire_o,
	output logic [XLEN-1:0] retire_pc_o,
	output logic            halt_o,
	output logic            illegal_o
);

	logic [4:0]      rs1_addr, rs2_addr;
	logic [XLEN-1:0] rs1_data, rs2_data;
	logic            reg_wen;
	logic [4:0]      reg_waddr;
	logic [XLEN-1:0] reg_wdata;
	logic            redirect;
	logic [XLEN-1:0] redirect_pc;

	stage_if #(.payload_t(fetch_pl_t))  f2d ();
	stage_if #(.payload_t(decode_pl_t)) d2e ();
	stage_if #(.payload_t(exec_pl_t))   e2m ();
	stage_if #(.payload_t(wb_pl_t))     m2w ();

	ifu #(
		.RESET_PC (RESET_PC)
	) u_ifu (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.inst_req_valid_o (inst_req_valid_o),
		.inst_req_ready_i (inst_req_ready_i),
		.inst_addr_o      (inst_addr_o),
		.inst_rsp_valid_i (inst_rsp_valid_i),
		.inst_rsp_ready_o (inst_rsp_ready_o),
		.inst_data_i      (inst_data_i),
		.retire_i         (retire_o),
		.redirect_i       (redirect),
		.redirect_pc_i    (redirect_pc),
		.halted_i         (halt_o),
		.fetch_o          (f2d.src)
	);

	regfile u_regfile (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data),
		.wen_i    (reg_wen),
		.waddr_i  (reg_waddr),
		.wdata_i  (reg_wdata)
	);

	idu u_idu (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.fetch_i    (f2d.dst),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.decode_o   (d2e.src),
		.illegal_o  (illegal_o)
	);

	exu u_exu (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.decode_i (d2e.dst),
		.exec_o   (e2m.src)
	);

	lsu u_lsu (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.exec_i           (e2m.dst),
		.data_req_valid_o (data_req_valid_o),
		.data_req_ready_i (data_req_ready_i),
		.data_we_o        (data_we_o),
		.data_addr_o      (data_addr_o),
		.data_wdata_o     (data_wdata_o),
		.data_rsp_valid_i (data_rsp_valid_i),
		.data_rsp_ready_o (data_rsp_ready_o),
		.data_rdata_i     (data_rdata_i),
		.mem_o            (m2w.src)
	);

	wbu u_wbu (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.mem_i         (m2w.dst),
		.reg_wen_o     (reg_wen),
		.reg_waddr_o   (reg_waddr),
		.reg_wdata_o   (reg_wdata),
		.retire_o      (retire_o),
		.retire_pc_o   (retire_pc_o),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc),
		.halted_o      (halt_o)
	);

endmodule

/* dv/tb_mem_model.sv */
module tb_mem_model (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        stall_en_i,

	input  logic        inst_req_valid_i,
	output logic        inst_req_ready_o,
	input  logic [31:0] inst_addr_i,
	output logic        inst_rsp_valid_o,
	input  logic        inst_rsp_ready_i,
	output logic [31:0] inst_data_o,

	input  logic        data_req_valid_i,
	output logic        data_req_ready_o,
	input  logic        data_we_i,
	input  logic [31:0] data_addr_i,
	input  logic [31:0] data_wdata_i,
	output logic        data_rsp_valid_o,
	input  logic        data_rsp_ready_i,
	output logic [31:0] data_rdata_o
);

	// word addressed memories of 1 KiB
	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];

	int          seed;
	int          i_wait;
	int          d_wait;
	logic        i_pend;
	logic        d_pend;
	logic        rst_act;
	logic        i_req_hs;
	logic        i_rsp_hs;
	logic        d_req_hs;
	logic        d_rsp_hs;
	logic [31:0] i_addr;
	logic [31:0] d_addr;
	logic [31:0] d_wdata;
	logic        d_we;

	// 0 to 3 cycles of response delay in stall mode
	function automatic int pick_delay();
		if (!stall_en_i)
			return 0;
		return $unsigned($random(seed)) % 4;
	endfunction

	function automatic logic pick_ready();
		if (!stall_en_i)
			return 1'b1;
		return ($random(seed) & 1) != 0;
	endfunction

	initial begin
		seed             = 73596;
		i_pend           = 1'b0;
		d_pend           = 1'b0;
		i_wait           = 0;
		d_wait           = 0;
		inst_req_ready_o = 1'b0;
		inst_rsp_valid_o = 1'b0;
		inst_data_o      = '0;
		data_req_ready_o = 1'b0;
		data_rsp_valid_o = 1'b0;
		data_rdata_o     = '0;
	end

	// sample mid cycle and answer just after the next rising edge
	always begin
		@(negedge clk);
		rst_act  = !arst_n_i;
		i_req_hs = inst_req_valid_i && inst_req_ready_o;
		i_rsp_hs = inst_rsp_valid_o && inst_rsp_ready_i;
		d_req_hs = data_req_valid_i && data_req_ready_o;
		d_rsp_hs = data_rsp_valid_o && data_rsp_ready_i;
		i_addr   = inst_addr_i;
		d_addr   = data_addr_i;
		d_we     = data_we_i;
		d_wdata  = data_wdata_i;
		@(posedge clk);
		#1;
		if (rst_act) begin
			i_pend           = 1'b0;
			d_pend           = 1'b0;
			inst_req_ready_o = 1'b0;
			inst_rsp_valid_o = 1'b0;
			data_req_ready_o = 1'b0;
			data_rsp_valid_o = 1'b0;
		end else begin
			// instruction side
			if (i_rsp_hs)
				inst_rsp_valid_o = 1'b0;
			if (i_req_hs) begin
				i_pend      = 1'b1;
				i_wait      = pick_delay();
				inst_data_o = imem[i_addr[9:2]];
			end
			if (i_pend) begin
				if (i_wait == 0) begin
					inst_rsp_valid_o = 1'b1;
					i_pend           = 1'b0;
				end else begin
					i_wait = i_wait - 1;
				end
			end
			inst_req_ready_o = !i_pend && !inst_rsp_valid_o && pick_ready();

			// data side
			// stores are written when the request is taken
			if (d_rsp_hs)
				data_rsp_valid_o = 1'b0;
			if (d_req_hs) begin
				if (d_we)
					dmem[d_addr[9:2]] = d_wdata;
				d_pend       = 1'b1;
				d_wait       = pick_delay();
				data_rdata_o = dmem[d_addr[9:2]];
			end
			if (d_pend) begin
				if (d_wait == 0) begin
					data_rsp_valid_o = 1'b1;
					d_pend           = 1'b0;
				end else begin
					d_wait = d_wait - 1;
				end
			end
			data_req_ready_o = !d_pend && !data_rsp_valid_o && pick_ready();
		end
	end

endmodule

/* dv/cpu_core_tb.sv */
module cpu_core_tb;

	localparam logic [31:0] RESET_PC     = 32'h0000_0000;
	localparam int          HALT_TIMEOUT = 5000;

	localparam logic [6:0] OPC_LUI   = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JALR  = 7'b1100111;
	localparam logic [6:0] OPC_LOAD  = 7'b0000011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [31:0] EBREAK   = 32'h0010_0073;

	logic        clk;
	logic        arst_n;
	logic        stall_en;
	logic        inst_req_valid;
	logic        inst_req_ready;
	logic [31:0] inst_addr;
	logic        inst_rsp_valid;
	logic        inst_rsp_ready;
	logic [31:0] inst_data;
	logic        data_req_valid;
	logic        data_req_ready;
	logic        data_we;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic        data_rsp_valid;
	logic        data_rsp_ready;
	logic [31:0] data_rdata;
	logic        retire;
	logic [31:0] retire_pc;
	logic        halt;
	logic        illegal;

	// observed and expected traces
	logic [31:0] retire_q [$];
	logic [31:0] st_addr_q [$];
	logic [31:0] st_data_q [$];
	logic [31:0] exp_pc_q [$];
	logic [31:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	int          load_idx;

	cpu_core #(
		.RESET_PC (RESET_PC)
	) uut (
		.clk              (clk),
		.arst_n_i         (arst_n),
		.inst_req_valid_o (inst_req_valid),
		.inst_req_ready_i (inst_req_ready),
		.inst_addr_o      (inst_addr),
		.inst_rsp_valid_i (inst_rsp_valid),
		.inst_rsp_ready_o (inst_rsp_ready),
		.inst_data_i      (inst_data),
		.data_req_valid_o (data_req_valid),
		.data_req_ready_i (data_req_ready),
		.data_we_o        (data_we),
		.data_addr_o      (data_addr),
		.data_wdata_o     (data_wdata),
		.data_rsp_valid_i (data_rsp_valid),
		.data_rsp_ready_o (data_rsp_ready),
		.data_rdata_i     (data_rdata),
		.retire_o         (retire),
		.retire_pc_o      (retire_pc),
		.halt_o           (halt),
		.illegal_o        (illegal)
	);

	tb_mem_model mem (
		.clk              (clk),
		.arst_n_i         (arst_n),
		.stall_en_i       (stall_en),
		.inst_req_valid_i (inst_req_valid),
		.inst_req_ready_o (inst_req_ready),
		.inst_addr_i      (inst_addr),
		.inst_rsp_valid_o (inst_rsp_valid),
		.inst_rsp_ready_i (inst_rsp_ready),
		.inst_data_o      (inst_data),
		.data_req_valid_i (data_req_valid),
		.data_req_ready_o (data_req_ready),
		.data_we_i        (data_we),
		.data_addr_i      (data_addr),
		.data_wdata_i     (data_wdata),
		.data_rsp_valid_o (data_rsp_valid),
		.data_rsp_ready_i (data_rsp_ready),
		.data_rdata_o     (data_rdata)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// record retirements and accepted stores
	always @(negedge clk) begin
		if (retire)
			retire_q.push_back(retire_pc);
		if (data_req_valid && data_req_ready && data_we) begin
			st_addr_q.push_back(data_addr);
			st_data_q.push_back(data_wdata);
		end
	end

	// instruction encoders
	function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] opc);
		return {imm[31:12], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [31:0] data_fill(input int idx);
		return 32'h5a5a_0000 | idx;
	endfunction

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %h, actual %h", test_name, expected, actual);
			stop_run();
		end
	endtask

	// imem fill decodes as an illegal opcode
	task automatic setup_test();
		for (int i = 0; i < 256; i++) begin
			mem.imem[i] = {i[24:0], 7'h7f};
			mem.dmem[i] = data_fill(i);
		end
		load_idx = 0;
		exp_pc_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic put_inst(input logic [31:0] word);
		mem.imem[(RESET_PC >> 2) + load_idx] = word;
		load_idx++;
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	// straight-line code retires every word in order
	task automatic expect_linear_pcs();
		for (int i = 0; i < load_idx; i++)
			exp_pc_q.push_back(RESET_PC + 4 * i);
	endtask

	task automatic run_program(input string test_name);
		int cycles;
		retire_q.delete();
		st_addr_q.delete();
		st_data_q.delete();
		@(posedge clk);
		#1;
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_value({test_name, " reset flags"}, 32'h0,
			{25'h0, halt, illegal, retire, inst_req_valid, inst_rsp_ready, data_req_valid,
			data_rsp_ready});
		check_value({test_name, " reset pc"}, RESET_PC, inst_addr);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > HALT_TIMEOUT) begin
				$display("test %s timed out waiting for the core to halt", test_name);
				stop_run();
			end
		end while (!halt);
		// the monitor records the halting retire on this same edge
		@(posedge clk);
		#1;
	endtask

	task automatic check_results(input string test_name);
		check_value({test_name, " retire count"}, exp_pc_q.size(), retire_q.size());
		foreach (exp_pc_q[i])
			check_value({test_name, " retire pc"}, exp_pc_q[i], retire_q[i]);
		check_value({test_name, " store count"}, exp_addr_q.size(), st_addr_q.size());
		foreach (exp_addr_q[i]) begin
			check_value({test_name, " store addr"}, exp_addr_q[i], st_addr_q[i]);
			check_value({test_name, " store data"}, exp_data_q[i], st_data_q[i]);
		end
	endtask

	task automatic test_alu(input string test_name);
		logic [31:0] results [12];
		setup_test();
		put_inst(i_type(5, 0, 3'b000, 1, OPC_OPIMM));
		put_inst(i_type(-3, 0, 3'b000, 2, OPC_OPIMM));
		put_inst(r_type(7'h00, 2, 1, 3'b000, 3));
		put_inst(r_type(7'h20, 2, 1, 3'b000, 4));
		put_inst(i_type(4, 1, 3'b001, 5, OPC_OPIMM));
		put_inst(r_type(7'h20, 1, 2, 3'b101, 6));
		put_inst(i_type(28, 2, 3'b101, 7, OPC_OPIMM));
		put_inst(r_type(7'h00, 1, 2, 3'b010, 8));
		put_inst(r_type(7'h00, 1, 2, 3'b011, 9));
		put_inst(i_type(12'h0ff, 1, 3'b100, 10, OPC_OPIMM));
		put_inst(r_type(7'h00, 5, 4, 3'b110, 11));
		put_inst(i_type(12'h7f0, 2, 3'b111, 12, OPC_OPIMM));
		put_inst(u_type(32'h1234_5000, 13, OPC_LUI));
		// auipc sits at 0x34
		put_inst(u_type(32'h0000_1000, 14, OPC_AUIPC));
		put_inst(i_type(12'h100, 0, 3'b000, 15, OPC_OPIMM));
		for (int r = 3; r <= 14; r++)
			put_inst(s_type((r - 3) * 4, r, 15));
		put_inst(EBREAK);
		results = '{32'h2, 32'h8, 32'h50, 32'hffff_ffff, 32'hf, 32'h1, 32'h0,
			32'hfa, 32'h58, 32'h7f0, 32'h1234_5000, 32'h1034};
		foreach (results[k])
			expect_store(32'h100 + 4 * k, results[k]);
		expect_linear_pcs();
		run_program(test_name);
		check_results(test_name);
	endtask

	task automatic test_load_store(input string test_name);
		setup_test();
		put_inst(i_type(12'h200, 0, 3'b000, 1, OPC_OPIMM));
		put_inst(u_type(32'habcd_e000, 2, OPC_LUI));
		put_inst(i_type(12'h123, 2, 3'b000, 2, OPC_OPIMM));
		put_inst(s_type(0, 2, 1));
		put_inst(i_type(0, 1, 3'b010, 3, OPC_LOAD));
		put_inst(i_type(1, 3, 3'b000, 3, OPC_OPIMM));
		put_inst(s_type(4, 3, 1));
		// untouched word still holds its fill value
		put_inst(i_type(8, 1, 3'b010, 4, OPC_LOAD));
		put_inst(s_type(12, 4, 1));
		put_inst(EBREAK);
		expect_store(32'h200, 32'habcd_e123);
		expect_store(32'h204, 32'habcd_e124);
		expect_store(32'h20c, data_fill(32'h208 >> 2));
		expect_linear_pcs();
		run_program(test_name);
		check_results(test_name);
	endtask

	task automatic test_branch(input string test_name);
		setup_test();
		put_inst(i_type(1, 0, 3'b000, 1, OPC_OPIMM));
		put_inst(i_type(-1, 0, 3'b000, 2, OPC_OPIMM));
		put_inst(b_type(8, 2, 1, 3'b000));
		put_inst(b_type(8, 2, 1, 3'b001));
		put_inst(i_type(1, 0, 3'b000, 9, OPC_OPIMM));
		put_inst(b_type(8, 1, 2, 3'b100));
		put_inst(i_type(2, 0, 3'b000, 9, OPC_OPIMM));
		put_inst(b_type(8, 1, 2, 3'b110));
		put_inst(b_type(8, 1, 2, 3'b101));
		put_inst(b_type(8, 1, 2, 3'b111));
		put_inst(i_type(3, 0, 3'b000, 9, OPC_OPIMM));
		put_inst(j_type(12, 5));
		put_inst(s_type(12'h100, 6, 0));
		put_inst(EBREAK);
		// jalr to 0x31 lands on 0x30 once bit 0 is cleared
		put_inst(i_type(1, 5, 3'b000, 6, OPC_JALR));
		// beq no, bne yes, blt yes, bltu no, bge no, bgeu yes, jal, jalr
		exp_pc_q = '{32'h00, 32'h04, 32'h08, 32'h0c, 32'h14, 32'h1c, 32'h20, 32'h24,
			32'h2c, 32'h38, 32'h30, 32'h34};
		expect_store(32'h100, 32'h3c);
		run_program(test_name);
		check_results(test_name);
	endtask

	task automatic test_halt(input string test_name);
		setup_test();
		put_inst(i_type(7, 0, 3'b000, 1, OPC_OPIMM));
		put_inst(EBREAK);
		put_inst(i_type(8, 0, 3'b000, 1, OPC_OPIMM));
		exp_pc_q = '{RESET_PC, RESET_PC + 4};
		run_program(test_name);
		check_results(test_name);
		check_value({test_name, " halt_o"}, 1, halt);
		check_value({test_name, " illegal_o"}, 0, illegal);
		repeat (40) begin
			@(negedge clk);
			if (inst_req_valid) begin
				$display("test %s saw a fetch request after the core halted", test_name);
				stop_run();
			end
		end
	endtask

	task automatic test_illegal(input string test_name);
		setup_test();
		put_inst(i_type(7, 0, 3'b000, 1, OPC_OPIMM));
		put_inst(32'hffff_ffff);
		exp_pc_q = '{RESET_PC, RESET_PC + 4};
		run_program(test_name);
		check_results(test_name);
		check_value({test_name, " illegal_o"}, 1, illegal);
		check_value({test_name, " halt_o"}, 1, halt);
	endtask

	initial begin
		arst_n   = 1'b0;
		stall_en = 1'b0;
		load_idx = 0;
		test_alu("alu");
		test_load_store("load_store");
		test_branch("branch");
		// same program with random ready and response delays
		stall_en = 1'b1;
		test_alu("backpressure");
		stall_en = 1'b0;
		test_halt("halt");
		test_illegal("illegal");
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* build.f */
source/rv_isa_pkg.sv
source/core_types_pkg.sv
source/stage_if.sv
source/ifu.sv
source/regfile.sv
source/idu.sv
source/exu.sv
source/lsu.sv
source/wbu.sv
source/cpu_core.sv
dv/tb_mem_model.sv
dv/cpu_core_tb.sv
